/* design/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
(
  input  logic                      clk,
  input  logic                      rst_n,

  // memory port, req/gnt/rvalid
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output lsu_types_pkg::word_t      data_addr_o,
  output logic                      data_we_o,
  output lsu_types_pkg::be_t        data_be_o,
  output lsu_types_pkg::word_t      data_wdata_o,
  input  lsu_types_pkg::word_t      data_rdata_i,

  // ex stage side
  input  logic                      data_req_ex_i,
  input  logic                      data_we_ex_i,
  input  lsu_types_pkg::data_size_t data_type_ex_i,       // 0 word, 1 half, 2/3 byte
  input  lsu_types_pkg::word_t      data_wdata_ex_i,
  input  lsu_types_pkg::byte_off_t  data_reg_offset_ex_i, // byte position in register
  input  logic                      data_sign_ext_ex_i,
  input  lsu_types_pkg::word_t      operand_a_ex_i,
  input  lsu_types_pkg::word_t      operand_b_ex_i,
  input  logic                      addr_useincr_ex_i,
  input  logic                      data_misaligned_ex_i, // second part of a split
  input  logic                      ex_valid_i,

  output lsu_types_pkg::word_t      data_rdata_ex_o,
  output logic                      data_misaligned_o,    // to the core controller
  output logic                      lsu_ready_ex_o,
  output logic                      lsu_ready_wb_o
);

  import lsu_types_pkg::*;

  // attributes of the granted access
  data_size_t size_q;
  byte_off_t  offset_q;
  logic       sign_ext_q;
  logic       we_q;

  assign data_we_o = data_we_ex_i;

  lsu_req_align u_req_align (
    .operand_a_i         (operand_a_ex_i),
    .operand_b_i         (operand_b_ex_i),
    .addr_useincr_i      (addr_useincr_ex_i),
    .req_i               (data_req_ex_i),
    .size_i              (data_type_ex_i),
    .wdata_i             (data_wdata_ex_i),
    .reg_offset_i        (data_reg_offset_ex_i),
    .misaligned_second_i (data_misaligned_ex_i),
    .addr_o              (data_addr_o),
    .be_o                (data_be_o),
    .wdata_o             (data_wdata_o),
    .misaligned_o        (data_misaligned_o)
  );

  lsu_access_ctrl u_access_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_ex_i      (data_req_ex_i),
    .we_ex_i       (data_we_ex_i),
    .size_ex_i     (data_type_ex_i),
    .sign_ext_ex_i (data_sign_ext_ex_i),
    .offset_i      (data_addr_o[1:0]),  // low address bits
    .gnt_i         (data_gnt_i),
    .rvalid_i      (data_rvalid_i),
    .ex_valid_i    (ex_valid_i),
    .data_req_o    (data_req_o),
    .ready_ex_o    (lsu_ready_ex_o),
    .ready_wb_o    (lsu_ready_wb_o),
    .size_q_o      (size_q),
    .offset_q_o    (offset_q),
    .sign_ext_q_o  (sign_ext_q),
    .we_q_o        (we_q)
  );

  lsu_rdata_align u_rdata_align (
    .clk              (clk),
    .rst_n            (rst_n),
    .rvalid_i         (data_rvalid_i),
    .rdata_i          (data_rdata_i),
    .size_q_i         (size_q),
    .offset_q_i       (offset_q),
    .sign_ext_q_i     (sign_ext_q),
    .we_q_i           (we_q),
    .misaligned_ex_i  (data_misaligned_ex_i),
    .misaligned_det_i (data_misaligned_o),
    .rdata_o          (data_rdata_ex_o)
  );

endmodule

/* design/lsu_access_ctrl.sv */
`timescale 1ns/1ps

module lsu_access_ctrl
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      req_ex_i,      // access request from ex
  input  logic                      we_ex_i,       // store when high
  input  lsu_types_pkg::data_size_t size_ex_i,     // access size from ex
  input  logic                      sign_ext_ex_i, // load sign extension
  input  lsu_types_pkg::byte_off_t  offset_i,      // low address bits
  input  logic                      gnt_i,         // memory accepted request
  input  logic                      rvalid_i,      // memory response
  input  logic                      ex_valid_i,    // ex stage advances

  output logic                      data_req_o,    // request to memory
  output logic                      ready_ex_o,    // lsu can take a new ex access
  output logic                      ready_wb_o,    // wb may advance
  output lsu_types_pkg::data_size_t size_q_o,      // attributes of granted access
  output lsu_types_pkg::byte_off_t  offset_q_o,
  output logic                      sign_ext_q_o,
  output logic                      we_q_o
);

  import lsu_types_pkg::*;
  import lsu_ctrl_pkg::*;

  lsu_state_t state_q, state_d;

  data_size_t size_q;
  byte_off_t  offset_q;
  logic       sign_ext_q;
  logic       we_q;
  logic       accept;  // request and grant in the same cycle

  assign accept = data_req_o & gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // next state and handshake outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      ST_IDLE:
      begin
        data_req_o = req_ex_i;  // pass the request straight through
        if (req_ex_i)
        begin
          ready_ex_o = gnt_i;  // ex waits until grant
          if (gnt_i)
            state_d = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
        end
      end

      ST_WAIT_RVALID:
      begin
        ready_wb_o = rvalid_i;  // wb blocked until the response
        if (rvalid_i)
        begin
          data_req_o = req_ex_i;  // next access may overlap the response
          if (req_ex_i)
          begin
            ready_ex_o = gnt_i;
            if (gnt_i)
              state_d = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
            else
              state_d = ST_IDLE;  // retry from idle
          end
          else
            state_d = ST_IDLE;
        end
      end

      ST_WAIT_RVALID_EX_STALL:
      begin
        // same access still sits in ex, so nothing new goes out
        if (rvalid_i)
          state_d = ex_valid_i ? ST_IDLE : ST_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = ST_WAIT_RVALID;  // stall released before the response
      end

      ST_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = ST_IDLE;
      end

      default: state_d = ST_IDLE;
    endcase
  end

  // state register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // attributes for the returning load data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= SIZE_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (accept)  // kept until the next grant, rvalid uses them
    begin
      size_q     <= size_ex_i;
      offset_q   <= offset_i;
      sign_ext_q <= sign_ext_ex_i;
      we_q       <= we_ex_i;
    end
  end

  assign size_q_o     = size_q;
  assign offset_q_o   = offset_q;
  assign sign_ext_q_o = sign_ext_q;
  assign we_q_o       = we_q;

endmodule

/* design/lsu_ctrl_pkg.sv */
package lsu_ctrl_pkg;

  // states of the access controller
  //   ST_IDLE                  no access outstanding
  //   ST_WAIT_RVALID           granted, waiting for the read/write response
  //   ST_WAIT_RVALID_EX_STALL  granted while ex was stalled, no new request
  //   ST_IDLE_EX_STALL         response seen, ex still stalled
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_RVALID,
    ST_WAIT_RVALID_EX_STALL,
    ST_IDLE_EX_STALL
  } lsu_state_t;

endpackage

/* design/lsu_rdata_align.sv */
`timescale 1ns/1ps

module lsu_rdata_align
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      rvalid_i,         // memory response
  input  lsu_types_pkg::word_t      rdata_i,          // raw word from memory
  input  lsu_types_pkg::data_size_t size_q_i,         // size of the granted access
  input  lsu_types_pkg::byte_off_t  offset_q_i,       // its byte offset
  input  logic                      sign_ext_q_i,     // sign or zero extend
  input  logic                      we_q_i,           // response belongs to a store
  input  logic                      misaligned_ex_i,  // second part in ex
  input  logic                      misaligned_det_i, // first part of a split in ex

  output lsu_types_pkg::word_t      rdata_o           // value toward the register file
);

  import lsu_types_pkg::*;

  word_t rdata_q;     // last load result, or first word of a split load
  word_t word_ext;    // word, assembled when split
  word_t half_ext;
  word_t byte_ext;
  word_t rdata_ext;   // selected by size

  logic [15:0] half_sel;
  logic [7:0]  byte_sel;

  ////////////////////////////////////////////////////////////////////////////
  // lane extraction
  ////////////////////////////////////////////////////////////////////////////

  // misaligned words take their low bytes from the held first word
  always_comb
  begin
    case (offset_q_i)
      2'd0: word_ext = rdata_i;
      2'd1: word_ext = {rdata_i[7:0],  rdata_q[31:8]};
      2'd2: word_ext = {rdata_i[15:0], rdata_q[31:16]};
      default: word_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_q_i)
      2'd0: half_sel = rdata_i[15:0];
      2'd1: half_sel = rdata_i[23:8];
      2'd2: half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  always_comb
  begin
    case (offset_q_i)
      2'd0: byte_sel = rdata_i[7:0];
      2'd1: byte_sel = rdata_i[15:8];
      2'd2: byte_sel = rdata_i[23:16];
      default: byte_sel = rdata_i[31:24];
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // sign extension and size select
  ////////////////////////////////////////////////////////////////////////////

  assign half_ext = sign_ext_q_i ? {{16{half_sel[15]}}, half_sel} : {16'h0000, half_sel};
  assign byte_ext = sign_ext_q_i ? {{24{byte_sel[7]}}, byte_sel} : {24'h00_0000, byte_sel};

  always_comb
  begin
    case (size_q_i)
      SIZE_WORD: rdata_ext = word_ext;
      SIZE_HALF: rdata_ext = half_ext;
      default:   rdata_ext = byte_ext;  // codes 2 and 3
    endcase
  end

  // hold register, loads only
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rvalid_i && !we_q_i)
    begin
      // raw word while a split access is in flight, result otherwise
      if (misaligned_ex_i || misaligned_det_i)
        rdata_q <= rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // live value in the response cycle, held value after it
  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

/* design/lsu_req_align.sv */
`timescale 1ns/1ps

module lsu_req_align
(
  input  lsu_types_pkg::word_t      operand_a_i,         // base register
  input  lsu_types_pkg::word_t      operand_b_i,         // offset / increment
  input  logic                      addr_useincr_i,      // 1: a + b, 0: a only
  input  logic                      req_i,               // access request from ex
  input  lsu_types_pkg::data_size_t size_i,              // word, half or byte
  input  lsu_types_pkg::word_t      wdata_i,             // store data from register
  input  lsu_types_pkg::byte_off_t  reg_offset_i,        // byte position in register
  input  logic                      misaligned_second_i, // second part of a split access

  output lsu_types_pkg::word_t      addr_o,              // byte address to memory
  output lsu_types_pkg::be_t        be_o,                // lane enables
  output lsu_types_pkg::word_t      wdata_o,             // lane aligned store data
  output logic                      misaligned_o         // split access needed
);

  import lsu_types_pkg::*;

  byte_off_t addr_off;  // lane of the first byte
  byte_off_t rot_off;   // rotation for the store data

  // address generation, post-increment modes pass a through
  assign addr_o   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_o[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    be_o = '0;
    case (size_i)
      SIZE_WORD:
      begin
        if (!misaligned_second_i)
        begin
          case (addr_off)  // upper lanes from the offset on
            2'd0: be_o = 4'b1111;
            2'd1: be_o = 4'b1110;
            2'd2: be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
        else
        begin
          // second part covers the lanes below the offset
          case (addr_off)
            2'd0: be_o = 4'b0000;  // never split, kept for completeness
            2'd1: be_o = 4'b0001;
            2'd2: be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end
      end

      SIZE_HALF:
      begin
        if (!misaligned_second_i)
        begin
          case (addr_off)
            2'd0: be_o = 4'b0011;
            2'd1: be_o = 4'b0110;
            2'd2: be_o = 4'b1100;
            default: be_o = 4'b1000;  // low byte only, rest in part two
          endcase
        end
        else
          be_o = 4'b0001;  // high byte of an offset-3 half
      end

      default:  // byte, codes 2 and 3
      begin
        be_o = be_t'(1) << addr_off;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////////////////////

  // move the register byte at reg_offset onto the addressed lane,
  // wraps mod 4 so the same rotation serves both parts of a split store
  assign rot_off = addr_off - reg_offset_i;

  always_comb
  begin
    case (rot_off)
      2'd0: wdata_o = wdata_i;
      2'd1: wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2: wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0], wdata_i[31:8]};
    endcase
  end

  // misalignment detect, only on the first part of an access
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i && !misaligned_second_i)
    begin
      if (size_i == SIZE_WORD)
        misaligned_o = (addr_off != 2'd0);  // any offset crosses the word
      else if (size_i == SIZE_HALF)
        misaligned_o = (addr_off == 2'd3);  // only the top lane crosses
    end
  end

endmodule

/* design/lsu_types_pkg.sv */
package lsu_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data path geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned BYTES_PER_WORD = 4;  // byte lanes on the memory port

  typedef logic [8*BYTES_PER_WORD-1:0] word_t;  // data word or byte address
  typedef logic [BYTES_PER_WORD-1:0]   be_t;    // one enable bit per lane

  // byte position inside a word, low address bits
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_off_t;

  ////////////////////////////////////////////////////////////////////////////
  // access size codes
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] data_size_t;  // encoding from the ex stage

  localparam data_size_t SIZE_WORD = 2'd0;  // 32 bit
  localparam data_size_t SIZE_HALF = 2'd1;  // 16 bit
  localparam data_size_t SIZE_BYTE = 2'd2;  // 8 bit, code 3 decodes the same way

  // code 3 has no own name, the decoders fall into the byte branch for it
  // through their default items

endpackage

/* verification/lsu_chk.sv */
`timescale 1ns/1ps

module lsu_chk
(
  input logic                     clk,
  input logic                     rst_n,
  input lsu_ctrl_pkg::lsu_state_t state_i,    // controller state
  input logic                     gnt_i,
  input logic                     rvalid_i,
  input logic                     data_req_i,
  input lsu_types_pkg::byte_off_t offset_i    // low address bits seen by the controller
);

  import lsu_ctrl_pkg::*;

  int unsigned fail_cnt = 0;  // failed assertion count

  ////////////////////////////////////////////////////////////////////////////
  // memory port protocol
  ////////////////////////////////////////////////////////////////////////////

  // a new grant may only overlap the response of the previous access
  gnt_in_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
    ((state_i == ST_WAIT_RVALID || state_i == ST_WAIT_RVALID_EX_STALL) && gnt_i) |-> rvalid_i)
    else
    begin
      $error("grant in wait state without rvalid");
      fail_cnt++;
    end

  no_rvalid_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ST_IDLE) |-> !rvalid_i)   // nothing outstanding in idle
    else
    begin
      $error("rvalid while idle");
      fail_cnt++;
    end

  addr_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !$isunknown(offset_i))
    else
    begin
      $error("unknown address during request");
      fail_cnt++;
    end

endmodule

bind lsu_access_ctrl lsu_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .state_i    (state_q),
  .gnt_i      (gnt_i),
  .rvalid_i   (rvalid_i),
  .data_req_i (data_req_o),
  .offset_i   (offset_i)
);

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 20;  // 40 ns clock
  localparam int RST_CYCLES  = 16;

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // release away from the active edge
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

/* verification/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;

  import lsu_types_pkg::*;

  localparam int HALF     = 20;    // half clock period in ns
  localparam int MEM_WDS  = 64;    // model depth in words, 256 bytes
  localparam int N_RAND   = 40;    // random accesses in the last test
  localparam int PLANNED  = 6 + 5 + 14 + 4 + 6 + 2*N_RAND;  // split parts count twice
  localparam int LIMIT    = 16 + 20*PLANNED;

  logic clk, rst_n;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  word_t data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  be_t data_be_o;
  logic data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i, addr_useincr_ex_i;
  logic data_misaligned_ex_i, ex_valid_i;
  data_size_t data_type_ex_i;
  word_t data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  byte_off_t data_reg_offset_ex_i;
  logic data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o;

  word_t mem [MEM_WDS];   // memory model contents
  word_t exp_q [$];       // expected load results in order
  int seed = 82;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int err_start = 0;
  int cycles = 0;
  logic chk_armed = 1'b0;  // final part of a load is in flight
  logic stall_en = 1'b0;   // random ex_valid drops
  word_t last_load = '0;
  logic busy = 1'b0;
  int gnt_cnt = 0;
  int rv_cnt = 0;
  logic [5:0] rd_idx = '0;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  load_store_unit dut_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic [7:0] mem_byte(input logic [7:0] a);
    word_t w;
    w = mem[a[7:2]];
    mem_byte = w[8*a[1:0] +: 8];  // little endian lanes
  endfunction

  function automatic word_t ref_load(input word_t addr, input data_size_t size, input logic sgn);
    word_t raw;
    raw = {mem_byte(addr[7:0] + 8'd3), mem_byte(addr[7:0] + 8'd2),
           mem_byte(addr[7:0] + 8'd1), mem_byte(addr[7:0])};
    case (size)
      SIZE_WORD: ref_load = raw;
      SIZE_HALF: ref_load = sgn ? {{16{raw[15]}}, raw[15:0]} : {16'h0, raw[15:0]};
      default:   ref_load = sgn ? {{24{raw[7]}}, raw[7:0]} : {24'h0, raw[7:0]};
    endcase
  endfunction

  function automatic be_t exp_be(input data_size_t size, input byte_off_t off, input logic second);
    be_t v;
    if (!second)
      v = (size == SIZE_WORD) ? (be_t'(4'hF) << off) :
          (size == SIZE_HALF) ? (be_t'(4'h3) << off) : (be_t'(1) << off);
    else
      v = (size == SIZE_WORD) ? ((be_t'(1) << off) - be_t'(1)) : be_t'(1);  // lanes below
    exp_be = v;
  endfunction

  // compare the load result in the cycle of its final rvalid,
  // a step ahead of the driver so a first-part response is never taken
  always @(negedge clk)
  begin
    #(HALF - 2);
    if (rst_n && chk_armed && data_rvalid_i)
    begin
      check_val("data_rdata_ex_o", data_rdata_ex_o, exp_q.pop_front());
      chk_armed = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model, one access outstanding, grant may meet the response
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    #1;  // after the ex inputs have settled
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    if (rst_n)
    begin
      if (busy)
      begin
        if (rv_cnt == 0)
        begin
          data_rvalid_i = 1'b1;
          data_rdata_i  = mem[rd_idx];
          busy          = 1'b0;
        end
        else
          rv_cnt--;
      end
      #1;  // request may follow the response combinationally
      if (!busy && data_req_o)
      begin
        if (gnt_cnt == 0)
        begin
          data_gnt_i = 1'b1;
          rd_idx     = data_addr_o[7:2];
          if (data_we_o)
            for (int i = 0; i < BYTES_PER_WORD; i++)
              if (data_be_o[i])
                mem[rd_idx][8*i +: 8] = data_wdata_o[8*i +: 8];
          busy    = 1'b1;
          rv_cnt  = $unsigned($random(seed)) % 3;   // rvalid 1..3 cycles later
          gnt_cnt = $unsigned($random(seed)) % 4;   // next grant after 0..3
        end
        else
          gnt_cnt--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // core emulation
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic ex_ok();
    ex_ok = stall_en ? (($unsigned($random(seed)) % 4) != 0) : 1'b1;
  endfunction

  task automatic do_access(input logic we, input data_size_t size, input word_t addr,
                           input word_t wdata, input byte_off_t roff, input logic sgn);
    logic split;
    word_t exp_val;
    word_t off_b;
    int rot;
    begin
      split = (size == SIZE_WORD && addr[1:0] != 2'd0) ||
              (size == SIZE_HALF && addr[1:0] == 2'd3);
      exp_val = ref_load(addr, size, sgn);
      rot = 8 * ((addr[1:0] - roff) & 3);
      for (int part = 0; part <= int'(split); part++)
      begin
        @(negedge clk);
        data_req_ex_i        = 1'b1;
        data_we_ex_i         = we;
        data_type_ex_i       = size;
        data_wdata_ex_i      = wdata;
        data_reg_offset_ex_i = roff;
        data_sign_ext_ex_i   = sgn;
        data_misaligned_ex_i = (part == 1);
        ex_valid_i           = ex_ok();
        if (part == 0 && $random(seed) % 2 == 0)
        begin
          off_b             = $unsigned($random(seed)) % 64;  // base plus offset form
          operand_a_ex_i    = addr - off_b;
          operand_b_ex_i    = off_b;
          addr_useincr_ex_i = 1'b1;
        end
        else
        begin
          operand_a_ex_i    = (part == 1) ? addr + 32'd4 : addr;
          operand_b_ex_i    = $random(seed);
          addr_useincr_ex_i = 1'b0;
        end
        #(HALF - 1);
        check_val("data_addr_o", data_addr_o, (part == 1) ? addr + 32'd4 : addr);
        check_val("data_be_o", data_be_o, exp_be(size, addr[1:0], part == 1));
        check_val("data_misaligned_o", data_misaligned_o, (part == 0) && split);
        check_val("data_we_o", data_we_o, we);
        if (part == 0 && !stall_en)
          check_val("data_req_o", data_req_o, 1'b1);  // idle passes the request on
        if (we)
          check_val("data_wdata_o", data_wdata_o,
                    (wdata << rot) | ((rot == 0) ? 32'h0 : (wdata >> (32 - rot))));
        while (!(data_req_o && data_gnt_i))
        begin
          if (data_req_o)
            check_val("lsu_ready_ex_o", lsu_ready_ex_o, 1'b0);  // grant withheld
          @(negedge clk);
          ex_valid_i = ex_ok();
          #(HALF - 1);
        end
      end
      if (!we)
      begin
        exp_q.push_back(exp_val);
        chk_armed = 1'b1;
        last_load = exp_val;
      end
      // wait for the response of the final part
      do
      begin
        @(negedge clk);
        data_req_ex_i        = 1'b0;
        data_misaligned_ex_i = 1'b0;
        ex_valid_i           = ex_ok();
        #(HALF - 1);
        check_val("data_req_o", data_req_o, 1'b0);  // nothing left to issue
        if (!stall_en && !data_rvalid_i)
          check_val("lsu_ready_wb_o", lsu_ready_wb_o, 1'b0);
      end
      while (!data_rvalid_i);
    end
  endtask

  task automatic hold_idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      data_req_ex_i = 1'b0;
      ex_valid_i    = 1'b0;  // ex stalled
      #(HALF - 1);
      check_val("data_rdata_ex_o", data_rdata_ex_o, last_load);
    end
    @(negedge clk);
    ex_valid_i = 1'b1;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - err_start);
    err_start = errors;
  endtask

  // run limit from the planned access count
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("timeout after %0d cycles, an access never completed", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial
  begin
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = SIZE_WORD;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i = 1'b0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i = 1'b1;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    for (int i = 0; i < MEM_WDS; i++)
      mem[i] = (i * 32'h0101_0101) ^ 32'h5A3C_96E1 ^ (i << 27);  // per address pattern
    wait (rst_n === 1'b1);

    do_access(1, SIZE_WORD, 32'h20, 32'hDEAD_BEEF, 0, 0);
    do_access(0, SIZE_WORD, 32'h20, 0, 0, 0);
    do_access(1, SIZE_HALF, 32'h26, 32'h0000_A55A, 0, 0);
    do_access(0, SIZE_HALF, 32'h26, 0, 0, 0);
    do_access(1, SIZE_BYTE, 32'h2B, 32'h0000_003C, 0, 0);
    do_access(0, SIZE_BYTE, 32'h2B, 0, 0, 0);
    end_test("aligned stores and loads");

    do_access(1, SIZE_WORD, 32'h40, 32'h80F0_8081, 0, 0);
    do_access(0, SIZE_BYTE, 32'h40, 0, 0, 1);
    do_access(0, SIZE_BYTE, 32'h40, 0, 0, 0);
    do_access(0, SIZE_HALF, 32'h42, 0, 0, 1);
    do_access(0, SIZE_HALF, 32'h42, 0, 0, 0);
    end_test("sign extension");

    do_access(1, SIZE_WORD, 32'h81, 32'h1122_3344, 0, 0);
    do_access(0, SIZE_WORD, 32'h81, 0, 0, 0);
    do_access(0, SIZE_WORD, 32'h86, 0, 0, 0);
    do_access(0, SIZE_WORD, 32'h8B, 0, 0, 0);
    do_access(1, SIZE_HALF, 32'h93, 32'h0000_BEEF, 0, 0);
    do_access(0, SIZE_HALF, 32'h93, 0, 0, 1);
    do_access(0, SIZE_HALF, 32'h93, 0, 0, 0);
    end_test("misaligned accesses");

    do_access(1, SIZE_BYTE, 32'h51, 32'hA1B2_C3D4, 0, 0);
    do_access(1, SIZE_BYTE, 32'h52, 32'hA1B2_C3D4, 3, 0);
    do_access(1, SIZE_HALF, 32'h52, 32'h1357_9BDF, 2, 0);
    do_access(1, SIZE_WORD, 32'h60, 32'h0F1E_2D3C, 1, 0);
    end_test("register offset stores");

    do_access(0, SIZE_WORD, 32'h20, 0, 0, 0);
    hold_idle(6);
    do_access(1, SIZE_WORD, 32'h70, 32'h7777_0000, 0, 0);
    hold_idle(6);
    do_access(0, SIZE_HALF, 32'h42, 0, 0, 1);
    hold_idle(3);
    end_test("stalls and hold");

    stall_en = 1'b1;
    for (int i = 0; i < N_RAND; i++)
      do_access($random(seed) % 2 == 0, $unsigned($random(seed)) % 4,
                $unsigned($random(seed)) % 256, $random(seed),
                $unsigned($random(seed)) % 4, $random(seed) % 2 == 0);
    stall_en = 1'b0;
    end_test("random traffic");

    if (dut_i.u_access_ctrl.u_chk.fail_cnt != 0)
    begin
      errors++;
      $display("protocol assertions failed %0d times", dut_i.u_access_ctrl.u_chk.fail_cnt);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verilog.f */
design/lsu_types_pkg.sv
design/lsu_ctrl_pkg.sv
design/lsu_req_align.sv
design/lsu_access_ctrl.sv
design/lsu_rdata_align.sv
design/load_store_unit.sv
verification/tb_clk_gen.sv
verification/lsu_chk.sv
verification/tb_lsu.sv
